//--- flist.f
mipsIssuePkg.sv
mipsDecoder.sv
issuePipe.sv
issueSequencer.sv
bubbleTimer.sv
mipsIssueTop.sv
mipsIssue_asserts.sv
mipsIssueTb.sv

//--- Bender.yml
package:
  name: mips_issue

sources:
  - mipsIssuePkg.sv
  - mipsDecoder.sv
  - issuePipe.sv
  - issueSequencer.sv
  - bubbleTimer.sv
  - mipsIssueTop.sv
  - target: test
    files:
      - mipsIssue_asserts.sv
      - mipsIssueTb.sv

//--- mipsIssueTb.sv
module mipsIssueTb import mipsIssuePkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int StallLimit = 10;
  localparam logic [19:0][5:0] TableOps = {OpSpecial, OpRegImm, OpJ, OpJal, OpBeq, OpBne,
    OpBlez, OpBgtz, OpAddi, OpSlti, OpAndi, OpOri, OpXori, OpMul, OpLb, OpLh, OpLw, OpSb,
    OpSh, OpSw};
  localparam logic [2:0][5:0] BranchOps = {OpBeq, OpJ, OpJal};

  logic      clk;
  logic      reset;
  logic      fetchValid;
  instWord_t fetchInst;
  logic      fetchStall;
  logic      issueValid;
  issue_t    issueOut;

  int          mismatchCount = 0;
  int          failCount = 0;
  int          cycleCount = 0;
  int          prevIssue = 0;
  int          lastIssue = 0;
  logic [31:0] seed = 32'hea21_b2ac;

  mipsIssueTop u_dut (
    .clk        (clk),
    .reset      (reset),
    .fetchValid (fetchValid),
    .fetchInst  (fetchInst),
    .fetchStall (fetchStall),
    .issueValid (issueValid),
    .issueOut   (issueOut)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycleCount <= cycleCount + 1;

  ////////////////////////////////////////////////////////////
  // helpers and reference decode
  ////////////////////////////////////////////////////////////

  function logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223; // lcg step
    return seed;
  endfunction

  // offsets 0, 7, 14 and 21 keep the four picks distinct and away from r0 and r31
  function automatic logic [4:0] regAt(input int base, input int k);
    return 5'((base + 7 * k) % 30 + 1);
  endfunction

  function automatic instWord_t rInst(input logic [5:0] op, input logic [4:0] rs, rt, rd,
                                      input logic [5:0] funct);
    return {op, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic instWord_t iInst(input logic [5:0] op, input logic [4:0] rs, rt);
    return {op, rs, rt, 16'(nextRand())};
  endfunction

  // f packs {regDst, memRead, memWrite, aluSrc, regWrite} and lh packs {jal, hazardClass}
  function automatic ctrl_t makeCtrl(input logic [4:0] f, input logic [3:0] alu,
                                     input logic [1:0] br, input logic [1:0] lh);
    return {f[4], f[3], f[3], alu, f[2], f[1], f[0], br, lh};
  endfunction

  function automatic issue_t refDecode(input instWord_t w);
    ctrl_t  c;
    issue_t r;
    case (w.rType.op)
      OpSpecial: c = (w.rType.funct == FunctJr) ? makeCtrl(5'b00010, AluPass, BrJumpReg, 2'b01)
                                                : makeCtrl(5'b10001, AluRtype, BrNone, 2'b00);
      OpMul:             c = makeCtrl(5'b10001, AluMul, BrNone, 2'b00);
      OpAddi:            c = makeCtrl(5'b00011, AluAddi, BrNone, 2'b01);
      OpAndi:            c = makeCtrl(5'b00011, AluAnd, BrNone, 2'b01);
      OpOri:             c = makeCtrl(5'b00011, AluOr, BrNone, 2'b01);
      OpXori:            c = makeCtrl(5'b00011, AluXor, BrNone, 2'b01);
      OpSlti:            c = makeCtrl(5'b00011, AluSlt, BrNone, 2'b01);
      OpLw, OpLh, OpLb:  c = makeCtrl(5'b01011, AluAdd, BrNone, 2'b01);
      OpSw, OpSh, OpSb:  c = makeCtrl(5'b00110, AluAdd, BrNone, 2'b00);
      OpBeq:             c = makeCtrl(5'b00000, AluBeq, BrCond, 2'b00);
      OpBne:             c = makeCtrl(5'b00000, AluBne, BrCond, 2'b00);
      OpBlez:            c = makeCtrl(5'b00000, AluBlez, BrCond, 2'b00);
      OpBgtz:            c = makeCtrl(5'b00000, AluBgtz, BrCond, 2'b01);
      OpRegImm: begin
        case (w.iType.rt) // regimm picks the branch by rt
          RegImmBgez: c = makeCtrl(5'b00000, AluBgez, BrCond, 2'b01);
          RegImmBltz: c = makeCtrl(5'b00000, AluBltz, BrCond, 2'b01);
          default:    c = '0;
        endcase
      end
      OpJ:               c = makeCtrl(5'b00000, AluPass, BrJump, 2'b01);
      OpJal:             c = makeCtrl(5'b00001, AluPass, BrJump, 2'b11);
      default:           c = '0;
    endcase
    if (w == '0) c = '0;
    r.ctrl = c;
    r.dest = !c.regWrite ? 5'd0 : c.jal ? LinkReg : c.regDst ? w.rType.rd : w.iType.rt;
    return r;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got, exp);
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    mismatchCount++;
  endtask

  // offers one word and returns at the falling edge after its acceptance
  task automatic pushInst(input instWord_t w, output int stalls);
    issue_t exp;
    exp = refDecode(w);
    stalls = 0;
    fetchValid = 1'b1;
    fetchInst = w;
    #1;
    while (fetchStall && stalls < StallLimit) begin
      @(negedge clk);
      stalls++;
      #1;
    end
    if (fetchStall) begin
      $display("instruction %h was never accepted, fetch stayed stalled", w);
      failCount++;
      @(negedge clk);
      fetchValid = 1'b0;
      return;
    end
    @(negedge clk);
    prevIssue = lastIssue;
    lastIssue = cycleCount;
    if (issueValid !== 1'b1) reportMismatch("issueValid", 32'(issueValid), 32'd1);
    if (issueOut !== exp) reportMismatch("issueOut", 32'(issueOut), 32'(exp));
  endtask

  task automatic idle(input int n);
    fetchValid = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic checkFlow(input int stalls, input int expStalls, input int expGap);
    if (stalls != expStalls) reportMismatch("fetchStall cycles", stalls, expStalls);
    if (lastIssue - prevIssue != expGap) reportMismatch("issue gap", lastIssue - prevIssue, expGap);
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic decodeTableSweep();
    instWord_t w;
    int        stalls;
    for (int i = 0; i < 20; i++) begin
      w = nextRand();
      w.rType.op = TableOps[i];
      pushInst(w, stalls);
      idle(4); // lets slots drain and branch hold end
    end
    pushInst(rInst(OpSpecial, 5'd9, 5'd0, 5'd0, FunctJr), stalls);
    if (issueOut.ctrl.regWrite !== 1'b0) reportMismatch("jr regWrite", 32'd1, 32'd0);
    idle(4);
    pushInst(iInst(OpRegImm, 5'd4, RegImmBgez), stalls);
    if (issueOut.ctrl.aluOp !== AluBgez) reportMismatch("bgez aluOp", 32'(issueOut.ctrl.aluOp),
                                                        32'(AluBgez));
    idle(4);
    pushInst(iInst(OpRegImm, 5'd4, RegImmBltz), stalls);
    if (issueOut.ctrl.aluOp !== AluBltz) reportMismatch("bltz aluOp", 32'(issueOut.ctrl.aluOp),
                                                        32'(AluBltz));
    idle(4);
    pushInst(iInst(OpJal, 5'd3, 5'd7), stalls);
    if (issueOut.dest !== LinkReg) reportMismatch("jal dest", 32'(issueOut.dest), 32'(LinkReg));
    idle(4);
  endtask

  task automatic nopAndUnknown();
    instWord_t w;
    int        stalls;
    pushInst('0, stalls);
    if (issueOut !== '0) reportMismatch("nop issueOut", 32'(issueOut), 32'd0);
    idle(2);
    w = nextRand();
    w.rType.op = 6'h3f; // unassigned opcode
    pushInst(w, stalls);
    if (issueOut !== '0) reportMismatch("unknown issueOut", 32'(issueOut), 32'd0);
    idle(4);
  endtask

  task automatic rawStall(input int base);
    int stalls;
    pushInst(iInst(OpAddi, regAt(base, 1), regAt(base, 0)), stalls);
    pushInst(rInst(OpSpecial, regAt(base, 2), regAt(base, 0), regAt(base, 3), 6'h20), stalls);
    checkFlow(stalls, 3, 4);
    idle(4);
    pushInst(iInst(OpAddi, regAt(base, 1), regAt(base, 0)), stalls);
    pushInst(iInst(OpLw, regAt(base, 2), regAt(base, 0)), stalls); // rt only a destination
    checkFlow(stalls, 0, 1);
    idle(4);
  endtask

  task automatic regZeroAndDistance(input int base);
    int stalls;
    pushInst(iInst(OpAddi, regAt(base, 1), 5'd0), stalls);
    pushInst(rInst(OpSpecial, 5'd0, regAt(base, 1), regAt(base, 3), 6'h20), stalls);
    checkFlow(stalls, 0, 1);
    idle(4);
    pushInst(iInst(OpAddi, regAt(base, 1), regAt(base, 0)), stalls);
    pushInst(iInst(OpAddi, regAt(base, 2), regAt(base, 3)), stalls);
    pushInst(iInst(OpOri, regAt(base, 2), regAt(base, 3)), stalls);
    pushInst(iInst(OpAndi, regAt(base, 2), regAt(base, 3)), stalls);
    pushInst(rInst(OpSpecial, regAt(base, 0), regAt(base, 1), regAt(base, 2), 6'h20), stalls);
    checkFlow(stalls, 0, 1); // producer already left the wb slot
    idle(4);
  endtask

  task automatic branchHold(input int base);
    int stalls;
    for (int k = 2; k >= 0; k--) begin
      pushInst(iInst(BranchOps[k], regAt(base, 1), regAt(base, 2)), stalls);
      pushInst(iInst(OpAddi, regAt(base, 2), regAt(base, 3)), stalls);
      checkFlow(stalls, 2, 3);
      idle(4);
    end
  endtask

  task automatic midStreamReset(input int base);
    int stalls;
    pushInst(iInst(OpJal, regAt(base, 1), regAt(base, 2)), stalls);
    reset = 1'b1; // mid-stream while the jump holds fetch
    fetchInst = iInst(OpAddi, regAt(base, 1), regAt(base, 0));
    fetchValid = 1'b1;
    @(negedge clk);
    if (issueValid !== 1'b0) reportMismatch("issueValid after reset", 32'(issueValid), 32'd0);
    if (fetchStall !== 1'b0) reportMismatch("fetchStall after reset", 32'(fetchStall), 32'd0);
    reset = 1'b0;
    idle(1);
    pushInst(iInst(OpAddi, regAt(base, 1), regAt(base, 0)), stalls);
    if (stalls != 0) reportMismatch("fetchStall cycles", stalls, 0);
    idle(4);
  endtask

  initial begin
    reset = 1'b1;
    fetchValid = 1'b0;
    fetchInst = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    decodeTableSweep();
    nopAndUnknown();
    rawStall(int'(nextRand() % 30));
    regZeroAndDistance(int'(nextRand() % 30));
    branchHold(int'(nextRand() % 30));
    midStreamReset(int'(nextRand() % 30));
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatchCount, failCount, u_dut.u_asserts.assertFails);
    if (mismatchCount + failCount + u_dut.u_asserts.assertFails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- mipsIssue_asserts.sv
module mipsIssueAsserts import mipsIssuePkg::*; (
  input logic   clk,
  input logic   reset,
  input logic   fetchStall,
  input logic   issueValid,
  input issue_t issueOut
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  ////////////////////////////////////////////////////////////
  // issue and stall timing
  ////////////////////////////////////////////////////////////

  branchHoldGap: assert property (@(posedge clk) disable iff (reset)
    issueValid && issueOut.ctrl.branchType != BrNone |=> !issueValid ##1 !issueValid)
    else begin
      $error("issue inside the hold window behind a branch");
      assertFails++;
    end

  stallAfterReset: assert property (@(posedge clk) reset |=> !fetchStall)
    else begin
      $error("fetchStall high right after reset");
      assertFails++;
    end

  // no destination without a register write
  destNeedsWrite: assert property (@(posedge clk) disable iff (reset)
    issueValid && !issueOut.ctrl.regWrite |-> issueOut.dest == '0)
    else begin
      $error("issued destination without regWrite");
      assertFails++;
    end

endmodule

bind mipsIssueTop mipsIssueAsserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .fetchStall (fetchStall),
  .issueValid (issueValid),
  .issueOut   (issueOut)
);

//--- mipsIssueTop.sv
module mipsIssueTop import mipsIssuePkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      fetchValid,
  input  instWord_t fetchInst,
  output logic      fetchStall,
  output logic      issueValid,
  output issue_t    issueOut
);

  ctrl_t      decCtrl;
  logic [4:0] decDest;
  logic       dataHazard;
  logic       accept;
  logic       timerLoad;
  logic       timerDone;

  mipsDecoder u_decoder (
    .inst (fetchInst),
    .ctrl (decCtrl),
    .dest (decDest)
  );

  issuePipe u_pipe (
    .clk        (clk),
    .reset      (reset),
    .inst       (fetchInst),
    .ctrl       (decCtrl),
    .dest       (decDest),
    .accept     (accept),
    .dataHazard (dataHazard),
    .issueValid (issueValid),
    .issueOut   (issueOut)
  );

  issueSequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .fetchValid (fetchValid),
    .dataHazard (dataHazard),
    .branchType (decCtrl.branchType),
    .timerDone  (timerDone),
    .accept     (accept),
    .fetchStall (fetchStall),
    .timerLoad  (timerLoad)
  );

  bubbleTimer u_timer (
    .clk   (clk),
    .reset (reset),
    .load  (timerLoad),
    .done  (timerDone)
  );

endmodule

//--- bubbleTimer.sv
module bubbleTimer import mipsIssuePkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic load,
  output logic done
);

  logic [1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      count <= BranchBubbles;
    end else if (count != '0) begin
      count <= count - 2'd1; // holds at zero
    end
  end

  // last hold cycle, count reaches zero at the coming edge
  assign done = (count == 2'd1);

endmodule

//--- issueSequencer.sv
module issueSequencer import mipsIssuePkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       fetchValid,
  input  logic       dataHazard,
  input  logic [1:0] branchType,
  input  logic       timerDone,
  output logic       accept,
  output logic       fetchStall,
  output logic       timerLoad
);

  logic state;
  logic nextState;

  // stall on a pending operand or while a branch resolves
  assign fetchStall = (state == StHold) || (fetchValid && dataHazard);
  assign accept     = fetchValid && !fetchStall;
  assign timerLoad  = accept && (branchType != BrNone);

  always_comb begin
    nextState = state;
    case (state)
      StRun: begin
        if (timerLoad) begin
          nextState = StHold;
        end
      end
      StHold: begin
        if (timerDone) begin
          nextState = StRun; // fetch resumes next cycle
        end
      end
      default: nextState = StRun;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= StRun;
    end else begin
      state <= nextState;
    end
  end

endmodule

//--- issuePipe.sv
module issuePipe import mipsIssuePkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  instWord_t  inst,
  input  ctrl_t      ctrl,
  input  logic [4:0] dest,
  input  logic       accept,
  output logic       dataHazard,
  output logic       issueValid,
  output issue_t     issueOut
);

  logic [4:0]      memDest;  // zero when the slot holds nothing
  logic [4:0]      wbDest;
  logic [2:0][4:0] liveDest;
  logic            useRs;
  logic            useRt;

  ////////////////////////////////////////////////////////////
  // slots
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      issueValid <= 1'b0;
      issueOut   <= '0;
      memDest    <= '0;
      wbDest     <= '0;
    end else begin
      issueValid <= accept;
      issueOut   <= accept ? issue_t'{ctrl: ctrl, dest: dest} : '0; // else bubble
      memDest    <= issueOut.dest;
      wbDest     <= memDest;
    end
  end

  ////////////////////////////////////////////////////////////
  // hazard compare
  ////////////////////////////////////////////////////////////

  assign liveDest = {wbDest, memDest, issueOut.dest};

  // nops, unknowns and plain jumps read no register
  assign useRs = (ctrl != '0) && (ctrl.branchType != BrJump);
  assign useRt = useRs && !ctrl.hazardClass;

  always_comb begin
    dataHazard = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (liveDest[i] != '0) begin // r0 never matches
        if (useRs && liveDest[i] == inst.rType.rs) begin
          dataHazard = 1'b1;
        end
        if (useRt && liveDest[i] == inst.rType.rt) begin
          dataHazard = 1'b1;
        end
      end
    end
  end

endmodule

//--- mipsDecoder.sv
module mipsDecoder import mipsIssuePkg::*; (
  input  instWord_t  inst,
  output ctrl_t      ctrl,
  output logic [4:0] dest
);

  ////////////////////////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl = '0; // unknown opcodes stay all zero
    case (inst.rType.op)
      OpSpecial: begin
        if (inst.rType.funct == FunctJr) begin
          ctrl.aluOp       = AluPass;
          ctrl.aluSrc      = 1'b1;
          ctrl.branchType  = BrJumpReg;
          ctrl.hazardClass = 1'b1; // target in rs
        end else begin
          ctrl.regDst   = 1'b1;
          ctrl.aluOp    = AluRtype;
          ctrl.regWrite = 1'b1;
        end
      end
      OpMul: begin
        ctrl.regDst   = 1'b1;
        ctrl.aluOp    = AluMul;
        ctrl.regWrite = 1'b1;
      end
      OpAddi, OpAndi, OpOri, OpXori, OpSlti: begin
        ctrl.aluSrc      = 1'b1;
        ctrl.regWrite    = 1'b1;
        ctrl.hazardClass = 1'b1;
        case (inst.rType.op)
          OpAndi:  ctrl.aluOp = AluAnd;
          OpOri:   ctrl.aluOp = AluOr;
          OpXori:  ctrl.aluOp = AluXor;
          OpSlti:  ctrl.aluOp = AluSlt;
          default: ctrl.aluOp = AluAddi;
        endcase
      end
      OpLw, OpLh, OpLb: begin
        ctrl.memRead     = 1'b1;
        ctrl.memToReg    = 1'b1;
        ctrl.aluOp       = AluAdd;
        ctrl.aluSrc      = 1'b1;
        ctrl.regWrite    = 1'b1;
        ctrl.hazardClass = 1'b1;
      end
      OpSw, OpSh, OpSb: begin // base and store data both read
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = AluAdd;
        ctrl.aluSrc   = 1'b1;
      end
      OpBeq, OpBne: begin
        ctrl.aluOp      = (inst.rType.op == OpBeq) ? AluBeq : AluBne;
        ctrl.branchType = BrCond;
      end
      OpBlez: begin
        ctrl.aluOp      = AluBlez;
        ctrl.branchType = BrCond;
      end
      OpBgtz: begin
        ctrl.aluOp       = AluBgtz;
        ctrl.branchType  = BrCond;
        ctrl.hazardClass = 1'b1;
      end
      OpRegImm: begin
        // second level on the rt field
        if (inst.iType.rt == RegImmBgez || inst.iType.rt == RegImmBltz) begin
          ctrl.aluOp       = (inst.iType.rt == RegImmBgez) ? AluBgez : AluBltz;
          ctrl.branchType  = BrCond;
          ctrl.hazardClass = 1'b1;
        end
      end
      OpJ: begin
        ctrl.aluOp       = AluPass;
        ctrl.branchType  = BrJump;
        ctrl.hazardClass = 1'b1;
      end
      OpJal: begin
        ctrl.aluOp       = AluPass;
        ctrl.regWrite    = 1'b1;
        ctrl.branchType  = BrJump;
        ctrl.jal         = 1'b1;
        ctrl.hazardClass = 1'b1;
      end
      default: ctrl = '0;
    endcase

    if (inst == '0) begin
      ctrl = '0; // nop
    end
  end

  ////////////////////////////////////////////////////////////
  // destination select
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (!ctrl.regWrite) begin
      dest = '0;
    end else if (ctrl.jal) begin
      dest = LinkReg;
    end else if (ctrl.regDst) begin
      dest = inst.rType.rd;
    end else begin
      dest = inst.iType.rt;
    end
  end

endmodule

//--- mipsIssuePkg.sv
package mipsIssuePkg;

  ////////////////////////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rType_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;     // also the regimm selector
    logic [15:0] imm;
  } iType_t;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } jType_t;

  typedef union packed {
    rType_t rType;
    iType_t iType;
    jType_t jType;
  } instWord_t;

  ////////////////////////////////////////////////////////////
  // decoded control
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       regDst;      // rd instead of rt
    logic       memRead;
    logic       memToReg;
    logic [3:0] aluOp;
    logic       memWrite;
    logic       aluSrc;      // immediate operand
    logic       regWrite;
    logic [1:0] branchType;
    logic       jal;
    logic       hazardClass; // 1 when only rs is read
  } ctrl_t;

  typedef struct packed {
    ctrl_t      ctrl;
    logic [4:0] dest;        // zero when nothing is written
  } issue_t;

  // opcodes
  localparam logic [5:0] OpSpecial = 6'b000000;
  localparam logic [5:0] OpRegImm  = 6'b000001;
  localparam logic [5:0] OpJ       = 6'b000010;
  localparam logic [5:0] OpJal     = 6'b000011;
  localparam logic [5:0] OpBeq     = 6'b000100;
  localparam logic [5:0] OpBne     = 6'b000101;
  localparam logic [5:0] OpBlez    = 6'b000110;
  localparam logic [5:0] OpBgtz    = 6'b000111;
  localparam logic [5:0] OpAddi    = 6'b001000;
  localparam logic [5:0] OpSlti    = 6'b001010;
  localparam logic [5:0] OpAndi    = 6'b001100;
  localparam logic [5:0] OpOri     = 6'b001101;
  localparam logic [5:0] OpXori    = 6'b001110;
  localparam logic [5:0] OpMul     = 6'b011100;
  localparam logic [5:0] OpLb      = 6'b100000;
  localparam logic [5:0] OpLh      = 6'b100001;
  localparam logic [5:0] OpLw      = 6'b100011;
  localparam logic [5:0] OpSb      = 6'b101000;
  localparam logic [5:0] OpSh      = 6'b101001;
  localparam logic [5:0] OpSw      = 6'b101011;
  localparam logic [5:0] FunctJr   = 6'b001000;

  localparam logic [4:0] RegImmBltz = 5'b00000;
  localparam logic [4:0] RegImmBgez = 5'b00001;

  // alu codes
  localparam logic [3:0] AluAdd   = 4'b0000; // address calc
  localparam logic [3:0] AluAddi  = 4'b0001;
  localparam logic [3:0] AluRtype = 4'b0010; // funct decides
  localparam logic [3:0] AluBgez  = 4'b0011;
  localparam logic [3:0] AluBeq   = 4'b0100;
  localparam logic [3:0] AluBne   = 4'b0101;
  localparam logic [3:0] AluBgtz  = 4'b0110;
  localparam logic [3:0] AluBlez  = 4'b0111;
  localparam logic [3:0] AluBltz  = 4'b1000;
  localparam logic [3:0] AluPass  = 4'b1001; // jumps
  localparam logic [3:0] AluAnd   = 4'b1010;
  localparam logic [3:0] AluOr    = 4'b1011;
  localparam logic [3:0] AluXor   = 4'b1100;
  localparam logic [3:0] AluSlt   = 4'b1101;
  localparam logic [3:0] AluMul   = 4'b1111;

  // branch types
  localparam logic [1:0] BrNone    = 2'd0;
  localparam logic [1:0] BrJump    = 2'd1;
  localparam logic [1:0] BrJumpReg = 2'd2;
  localparam logic [1:0] BrCond    = 2'd3;

  localparam logic [4:0] LinkReg       = 5'd31;
  localparam logic [1:0] BranchBubbles = 2'd2;

  // sequencer states
  localparam logic StRun  = 1'b0;
  localparam logic StHold = 1'b1;

endpackage
